// File: design/mmu_macros.svh
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// Number of fully associative TLB entries (two or more)
`define MMU_TLB_ENTRIES 4

// Translation table base width
// Base plus VA[31:20] plus two zero bits forms a 32-bit address
`define MMU_TBASE_BITS 18

`endif

// File: design/mmuPkg.sv
`default_nettype none

package mmuPkg;

  // Table walker states
  typedef enum logic [1:0] {IDLE, LEVEL1, LEVEL2} walkState;

  // Translation granule decides how many VA bits pass through
  typedef enum logic [1:0] {SECTION, LARGE, SMALL} pageSize;

  // First-level section descriptor
  typedef struct packed {
    logic [11:0] base;
    logic [17:0] rsvd;
    logic [1:0]  kind;
  } sectionView;

  // First-level coarse table pointer
  typedef struct packed {
    logic [21:0] base;
    logic [7:0]  rsvd;
    logic [1:0]  kind;
  } coarseView;

  // Second-level page descriptor
  // Small base is largeBase followed by smallLow
  typedef struct packed {
    logic [15:0] largeBase;
    logic [3:0]  smallLow;
    logic [9:0]  rsvd;
    logic [1:0]  kind;
  } pageView;

  // One fetched descriptor word read three ways
  typedef union packed {
    sectionView section;
    coarseView  coarse;
    pageView    page;
  } descWord;

  // TLB entry with tag and base from address bits 31..12
  typedef struct packed {
    logic        valid;
    logic [19:0] vtag;
    logic [19:0] pbase;
    pageSize     size;
  } tlbEntry;

endpackage

`default_nettype wire

// File: design/tlbIf.sv
`timescale 1ns/1ns
`default_nettype none

// Lookup and fill path between walker and TLB
interface tlbIf
  import mmuPkg::*;
();

  // Combinational lookup
  logic [31:0] lookupVa;
  logic        hit;
  logic [31:0] hitPa;

  // Fill written on the edge where fillEn is high
  logic        fillEn;
  logic [31:0] fillVa;
  logic [19:0] fillBase;
  pageSize     fillSize;

  modport walker (
    output lookupVa, fillEn, fillVa, fillBase, fillSize,
    input  hit, hitPa
  );

  modport tlb (
    input  lookupVa, fillEn, fillVa, fillBase, fillSize,
    output hit, hitPa
  );

endinterface

`default_nettype wire

// File: design/tlbCache.sv
`timescale 1ns/1ns
`default_nettype none
`include "mmu_macros.svh"

module tlbCache
  import mmuPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic flushTlb,
  tlbIf.tlb    tlb
);

  localparam int Entries = `MMU_TLB_ENTRIES;
  localparam int PtrBits = $clog2(Entries);

  tlbEntry            entries [Entries];
  logic [PtrBits-1:0] fillPtr;
  logic [Entries-1:0] hitVec;

  // Tag bits that take part in the compare for each granule
  function automatic logic [19:0] tagMask(input pageSize size);
    case (size)
      SECTION: tagMask = 20'hfff00;
      LARGE:   tagMask = 20'hffff0;
      default: tagMask = 20'hfffff;
    endcase
  endfunction

  // Physical address from stored base and untranslated VA bits
  function automatic logic [31:0] joinPa(input tlbEntry e, input logic [31:0] va);
    case (e.size)
      SECTION: joinPa = {e.pbase[19:8], va[19:0]};
      LARGE:   joinPa = {e.pbase[19:4], va[15:0]};
      default: joinPa = {e.pbase, va[11:0]};
    endcase
  endfunction

  // ============================================================
  // Lookup
  // ============================================================

  always_comb begin
    for (int i = 0; i < Entries; i++) begin
      hitVec[i] = entries[i].valid &&
                  (((entries[i].vtag ^ tlb.lookupVa[31:12]) & tagMask(entries[i].size)) == '0);
    end
  end

  // At most one hit, so last match wins harmlessly
  always_comb begin
    tlb.hitPa = '0;
    for (int i = 0; i < Entries; i++) begin
      if (hitVec[i]) begin
        tlb.hitPa = joinPa(entries[i], tlb.lookupVa);
      end
    end
  end

  assign tlb.hit = |hitVec;

  // ============================================================
  // Fill and flush
  // ============================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fillPtr <= '0;
      for (int i = 0; i < Entries; i++) begin
        entries[i] <= '0;
      end
    end else if (flushTlb) begin
      // Flush drops every entry and restarts replacement
      fillPtr <= '0;
      for (int i = 0; i < Entries; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (tlb.fillEn) begin
      entries[fillPtr] <= '{valid: 1'b1, vtag: tlb.fillVa[31:12],
                            pbase: tlb.fillBase, size: tlb.fillSize};
      // Round-robin pointer wraps for any depth
      fillPtr <= (fillPtr == PtrBits'(Entries - 1)) ? '0 : fillPtr + 1'b1;
    end
  end

  // Walker fills only after a miss, so entries never overlap
  aOneHit: assert property (@(posedge clk) disable iff (reset) $onehot0(hitVec))
    else $error("TLB: more than one entry hits");

endmodule

`default_nettype wire

// File: design/tableWalker.sv
`timescale 1ns/1ns
`default_nettype none
`include "mmu_macros.svh"

module tableWalker
  import mmuPkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       enable,
  input  logic                       req,
  input  logic [31:0]                va,
  input  logic [`MMU_TBASE_BITS-1:0] tableBase,
  input  logic [31:0]                memRdata,
  input  logic                       memReady,
  output logic                       memReq,
  output logic [31:0]                memAddr,
  output logic                       done,
  output logic                       fault,
  output logic [31:0]                pa,
  output logic [3:0]                 faultCode,
  tlbIf.walker                       walk
);

  walkState    state;
  descWord     desc;
  logic [21:0] coarseBase;
  logic        startReq;
  logic        walkDone;
  logic        walkFault;
  logic [3:0]  walkCode;
  logic [31:0] walkPa;
  logic [19:0] walkBase;
  pageSize     walkSize;

  // Fetched word seen through the descriptor views
  assign desc = descWord'(memRdata);

  // New request only in IDLE, and not while a result strobe is up
  assign startReq = (state == IDLE) && enable && req && !done && !fault;

  // ============================================================
  // Memory port
  // ============================================================

  assign memReq = (state == LEVEL1) || (state == LEVEL2);

  // Level one indexes by VA[31:20], level two by VA[19:12]
  assign memAddr = (state == LEVEL2) ? {coarseBase, va[19:12], 2'b00}
                                     : {tableBase, va[31:20], 2'b00};

  // ============================================================
  // Descriptor decode
  // ============================================================

  always_comb begin
    walkDone  = 1'b0;
    walkFault = 1'b0;
    walkCode  = 4'd0;
    walkPa    = '0;
    walkBase  = '0;
    walkSize  = SMALL;
    if (memReady) begin
      case (state)
        LEVEL1: begin
          case (desc.section.kind)
            // 1 MB section
            2'b10: begin
              walkDone = 1'b1;
              walkPa   = {desc.section.base, va[19:0]};
              walkBase = {desc.section.base, 8'h00};
              walkSize = SECTION;
            end
            // Coarse pointer needs a second fetch
            2'b01: ;
            // Fault or unsupported fine table
            default: begin
              walkFault = 1'b1;
              walkCode  = 4'd5;
            end
          endcase
        end
        LEVEL2: begin
          case (desc.page.kind)
            // 64 KB large page
            2'b01: begin
              walkDone = 1'b1;
              walkPa   = {desc.page.largeBase, va[15:0]};
              walkBase = {desc.page.largeBase, 4'h0};
              walkSize = LARGE;
            end
            // 4 KB small page
            2'b10: begin
              walkDone = 1'b1;
              walkPa   = {desc.page.largeBase, desc.page.smallLow, va[11:0]};
              walkBase = {desc.page.largeBase, desc.page.smallLow};
              walkSize = SMALL;
            end
            // Fault or tiny page
            default: begin
              walkFault = 1'b1;
              walkCode  = 4'd7;
            end
          endcase
        end
        default: ;
      endcase
    end
  end

  // ============================================================
  // TLB port
  // ============================================================

  assign walk.lookupVa = va;
  assign walk.fillVa   = va;
  assign walk.fillBase = walkBase;
  assign walk.fillSize = walkSize;
  // Fill lands on the edge where done rises
  assign walk.fillEn   = walkDone && enable;

  // ============================================================
  // State and results
  // ============================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else if (!enable) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (startReq && !walk.hit) state <= LEVEL1;
        LEVEL1:  if (memReady) state <= (desc.coarse.kind == 2'b01) ? LEVEL2 : IDLE;
        LEVEL2:  if (memReady) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Coarse table base held for the second fetch
  always_ff @(posedge clk) begin
    if (state == LEVEL1 && memReady) begin
      coarseBase <= desc.coarse.base;
    end
  end

  // One-cycle strobes
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      done  <= 1'b0;
      fault <= 1'b0;
    end else begin
      done  <= (startReq && walk.hit) || (walkDone && enable);
      fault <= walkFault && enable;
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (startReq && walk.hit) begin
      pa <= walk.hitPa;
    end else if (walkDone) begin
      pa <= walkPa;
    end
    if (walkFault) begin
      faultCode <= walkCode;
    end
  end

  aAddrStable: assert property (@(posedge clk) disable iff (reset)
    memReq && !memReady && enable |=> $stable(memAddr))
    else $error("Walker: memAddr changed while memReq waited");

  aNotBoth: assert property (@(posedge clk) disable iff (reset) !(done && fault))
    else $error("Walker: done and fault high together");

endmodule

`default_nettype wire

// File: design/faultRegs.sv
`timescale 1ns/1ns
`default_nettype none

module faultRegs (
  input  logic        clk,
  input  logic        reset,
  input  logic        fault,
  input  logic [3:0]  faultCode,
  input  logic [31:0] va,
  output logic [3:0]  faultStatus,
  output logic [31:0] faultAddr
);

  // ============================================================
  // Fault status and fault address
  // ============================================================

  // Loaded from the walker's fault pulse
  // New values visible the cycle after the pulse
  // Held until the next fault
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      faultStatus <= 4'd0;
      faultAddr   <= 32'd0;
    end else if (fault) begin
      // Code 5 for level one, 7 for level two
      faultStatus <= faultCode;
      // Requester still holds va during the pulse
      faultAddr   <= va;
    end
  end

endmodule

`default_nettype wire

// File: design/mmuTop.sv
`timescale 1ns/1ns
`default_nettype none
`include "mmu_macros.svh"

module mmuTop (
  input  logic                       clk,
  input  logic                       reset,
  // Requester
  input  logic                       req,
  input  logic [31:0]                va,
  output logic                       done,
  output logic [31:0]                pa,
  output logic                       fault,
  // Configuration
  input  logic                       enable,
  input  logic [`MMU_TBASE_BITS-1:0] tableBase,
  input  logic                       flushTlb,
  // Memory read port
  output logic                       memReq,
  output logic [31:0]                memAddr,
  input  logic [31:0]                memRdata,
  input  logic                       memReady,
  // Fault registers
  output logic [3:0]                 faultStatus,
  output logic [31:0]                faultAddr
);

  logic [3:0] faultCode;

  tlbIf tlbBus ();

  // ============================================================
  // TLB, walker, fault registers
  // ============================================================

  tlbCache u_tlbCache (
    .clk      (clk),
    .reset    (reset),
    .flushTlb (flushTlb),
    .tlb      (tlbBus.tlb)
  );

  tableWalker u_tableWalker (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .req       (req),
    .va        (va),
    .tableBase (tableBase),
    .memRdata  (memRdata),
    .memReady  (memReady),
    .memReq    (memReq),
    .memAddr   (memAddr),
    .done      (done),
    .fault     (fault),
    .pa        (pa),
    .faultCode (faultCode),
    .walk      (tlbBus.walker)
  );

  faultRegs u_faultRegs (
    .clk         (clk),
    .reset       (reset),
    .fault       (fault),
    .faultCode   (faultCode),
    .va          (va),
    .faultStatus (faultStatus),
    .faultAddr   (faultAddr)
  );

endmodule

`default_nettype wire

// File: verif/mmuTb.sv
`timescale 1ns/1ns
`default_nettype none
`include "mmu_macros.svh"

module mmuTb;

  // Level-one table at 0x0004_0000
  localparam logic [`MMU_TBASE_BITS-1:0] TableBase = 18'h00010;
  // Coarse table at 0x0005_0000
  localparam logic [21:0] CoarseBase = 22'h00140;
  localparam int Rows      = 15;
  localparam int WaitLimit = 40;

  // One translation request and what must come back
  typedef struct packed {
    logic [31:0] va;
    logic        flush;
    logic [31:0] pa;
    logic        fault;
    logic [3:0]  status;
    logic [1:0]  fetches;
  } stimRow;

  logic                       clk = 1'b0;
  logic                       reset;
  logic                       req;
  logic [31:0]                va;
  logic                       done;
  logic [31:0]                pa;
  logic                       fault;
  logic                       enable;
  logic [`MMU_TBASE_BITS-1:0] tableBase;
  logic                       flushTlb;
  logic                       memReq;
  logic [31:0]                memAddr;
  logic [31:0]                memRdata = 32'd0;
  logic                       memReady = 1'b0;
  logic [3:0]                 faultStatus;
  logic [31:0]                faultAddr;

  logic [31:0] pageMem [logic [31:0]];
  stimRow      rows [Rows];
  int          waitLeft = 0;
  int          fetchTotal = 0;

  // 20 ns period
  always #10 clk = ~clk;

  mmuTop u_mmuTop (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .va          (va),
    .done        (done),
    .pa          (pa),
    .fault       (fault),
    .enable      (enable),
    .tableBase   (tableBase),
    .flushTlb    (flushTlb),
    .memReq      (memReq),
    .memAddr     (memAddr),
    .memRdata    (memRdata),
    .memReady    (memReady),
    .faultStatus (faultStatus),
    .faultAddr   (faultAddr)
  );

  // ============================================================
  // Memory model
  // ============================================================

  function automatic logic [31:0] readWord(input logic [31:0] addr);
    if (pageMem.exists(addr)) begin
      return pageMem[addr];
    end
    // Unwritten words end in type 00, so they fault
    return (addr ^ 32'h5A5A_5A58) & 32'hFFFF_FFFC;
  endfunction

  // Ready after 0 to 3 idle cycles
  // One word per fetch
  always @(negedge clk) begin
    if (reset) begin
      memReady = 1'b0;
      waitLeft = 0;
    end else if (memReady) begin
      // Word taken on the last edge
      memReady = 1'b0;
      waitLeft = $urandom % 4;
    end else if (memReq) begin
      if (waitLeft == 0) begin
        memReady = 1'b1;
        memRdata = readWord(memAddr);
        fetchTotal++;
      end else begin
        waitLeft--;
      end
    end
  end

  task automatic loadPageTable();
    // Level one indexed by VA[31:20]
    pageMem[{TableBase, 12'h123, 2'b00}] = 32'h8AB0_0002;  // section at 0x8AB
    pageMem[{TableBase, 12'h200, 2'b00}] = 32'h0005_0001;  // coarse table at 0x50000
    pageMem[{TableBase, 12'h301, 2'b00}] = 32'h0000_0003;  // unsupported fine pointer
    // Coarse table indexed by VA[19:12]
    pageMem[{CoarseBase, 8'h34, 2'b00}] = 32'h7777_0001;  // large page
    pageMem[{CoarseBase, 8'h56, 2'b00}] = 32'h4321_5002;  // small page
    pageMem[{CoarseBase, 8'h70, 2'b00}] = 32'h0000_0003;  // unsupported tiny page
  endtask

  // ============================================================
  // Stimulus table
  // ============================================================

  // va, flush, pa, fault, faultStatus, fetches
  task automatic loadTable();
    rows[0]  = '{32'h1234_5678, 1'b0, 32'h8AB4_5678, 1'b0, 4'd0, 2'd1};
    rows[1]  = '{32'h1234_5678, 1'b0, 32'h8AB4_5678, 1'b0, 4'd0, 2'd0};
    rows[2]  = '{32'h2003_4ABC, 1'b0, 32'h7777_4ABC, 1'b0, 4'd0, 2'd2};
    rows[3]  = '{32'h2005_6DEF, 1'b0, 32'h4321_5DEF, 1'b0, 4'd0, 2'd2};
    rows[4]  = '{32'h2003_0010, 1'b0, 32'h7777_0010, 1'b0, 4'd0, 2'd0};
    rows[5]  = '{32'h123F_FFFF, 1'b0, 32'h8ABF_FFFF, 1'b0, 4'd0, 2'd0};
    // Fault rows
    // Each repeat walks again
    rows[6]  = '{32'h3015_0000, 1'b0, 32'h0000_0000, 1'b1, 4'd5, 2'd1};
    rows[7]  = '{32'h3015_0000, 1'b0, 32'h0000_0000, 1'b1, 4'd5, 2'd1};
    rows[8]  = '{32'h2007_0123, 1'b0, 32'h0000_0000, 1'b1, 4'd7, 2'd2};
    rows[9]  = '{32'h2007_0123, 1'b0, 32'h0000_0000, 1'b1, 4'd7, 2'd2};
    rows[10] = '{32'h7000_0000, 1'b0, 32'h0000_0000, 1'b1, 4'd5, 2'd1};
    // Flush, then the cached pages walk again
    rows[11] = '{32'h2005_6DEF, 1'b1, 32'h4321_5DEF, 1'b0, 4'd5, 2'd2};
    rows[12] = '{32'h2005_6000, 1'b0, 32'h4321_5000, 1'b0, 4'd5, 2'd0};
    rows[13] = '{32'h1234_5678, 1'b1, 32'h8AB4_5678, 1'b0, 4'd5, 2'd1};
    rows[14] = '{32'h1234_5678, 1'b0, 32'h8AB4_5678, 1'b0, 4'd5, 2'd0};
  endtask

  // ============================================================
  // Checks and waits
  // ============================================================

  task automatic expectEqual(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  // Counts cycles until done or fault and notes any memReq
  task automatic waitResult(output int cycles, output logic sawMemReq);
    cycles = 0;
    sawMemReq = 1'b0;
    do begin
      @(negedge clk);
      cycles++;
      if (memReq) begin
        sawMemReq = 1'b1;
      end
      if (cycles > WaitLimit) begin
        $display("Timeout: neither done nor fault arrived for va %h", va);
        $display("Checks failed");
        $fatal(1, "Stopped on timeout");
      end
    end while (!done && !fault);
  endtask

  initial begin
    int   cycles;
    int   startFetches;
    logic sawMemReq;
    void'($urandom(32'h2bfc));
    reset     = 1'b1;
    req       = 1'b0;
    va        = 32'd0;
    enable    = 1'b1;
    tableBase = TableBase;
    flushTlb  = 1'b0;
    loadPageTable();
    loadTable();
    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // Quiet outputs after reset
    expectEqual(32'(done), 32'd0, "done after reset");
    expectEqual(32'(fault), 32'd0, "fault after reset");
    expectEqual(32'(memReq), 32'd0, "memReq after reset");
    expectEqual(32'(faultStatus), 32'd0, "faultStatus after reset");
    expectEqual(faultAddr, 32'd0, "faultAddr after reset");

    for (int r = 0; r < Rows; r++) begin
      if (rows[r].flush) begin
        flushTlb = 1'b1;
        @(negedge clk);
        flushTlb = 1'b0;
      end
      startFetches = fetchTotal;
      req = 1'b1;
      va  = rows[r].va;
      waitResult(cycles, sawMemReq);

      // Strobe cycle
      expectEqual(32'(done), 32'(!rows[r].fault), $sformatf("row %0d done", r));
      expectEqual(32'(fault), 32'(rows[r].fault), $sformatf("row %0d fault", r));
      if (!rows[r].fault) begin
        expectEqual(pa, rows[r].pa, $sformatf("row %0d pa", r));
      end
      expectEqual(32'(sawMemReq), 32'(rows[r].fetches != 2'd0),
                  $sformatf("row %0d memReq seen", r));
      expectEqual(fetchTotal - startFetches, 32'(rows[r].fetches),
                  $sformatf("row %0d fetch count", r));
      // TLB hit answers one cycle after the request
      if (rows[r].fetches == 2'd0) begin
        expectEqual(cycles, 32'd1, $sformatf("row %0d hit latency", r));
      end

      req = 1'b0;
      @(negedge clk);
      // Strobes last one cycle
      // Fault registers now updated
      expectEqual(32'(done), 32'd0, $sformatf("row %0d done pulse", r));
      expectEqual(32'(fault), 32'd0, $sformatf("row %0d fault pulse", r));
      expectEqual(32'(faultStatus), 32'(rows[r].status),
                  $sformatf("row %0d faultStatus", r));
      if (rows[r].fault) begin
        expectEqual(faultAddr, rows[r].va, $sformatf("row %0d faultAddr", r));
      end
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/mmuPkg.sv
design/tlbIf.sv
design/tlbCache.sv
design/tableWalker.sv
design/faultRegs.sv
design/mmuTop.sv
verif/mmuTb.sv

// File: Makefile
TOP := mmuTb

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
